/* int_cluster.f */
+incdir+common
common/int_cluster_pkg.sv
issue/issue_queue.sv
src/instr_ram.sv
src/operand_stage.sv
src/int_alu.sv
src/int_cluster.sv
verification/int_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the integer cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f int_cluster.f \
    --top-module int_cluster_tb \
    -o int_cluster_sim

./obj_dir/int_cluster_sim | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

/* verification/int_cluster_tb.sv */
// Integer cluster testbench

`timescale 1ns/10ps

module int_cluster_tb import int_cluster_pkg::*; ();
    localparam int NROWS = 22;
    localparam int LIMIT = 20 * (NROWS + 1) + 200;

    localparam logic [1:0] M_RDY   = 2'd0;
    localparam logic [1:0] M_EU2   = 2'd1;
    localparam logic [1:0] M_PREV  = 2'd2;
    localparam logic [1:0] M_PAIR  = 2'd3;

    typedef struct packed {
        alu_op_t    op;
        logic       imm;
        xlen_t      immediate;
        preg_t      rs1;
        preg_t      rs2;
        preg_t      dest;
        pack_id_t   pack;
        logic       slot;
        logic [1:0] mode;
    } test_row_t;

    logic cpu_clock_i = 1'b0;
    logic rst_i;
    logic flush_i;
    alu_op_t ins0_op_i, ins1_op_i;
    logic ins0_imm_i, ins1_imm_i, ins0_valid_i, ins1_valid_i;
    xlen_t ins0_immediate_i, ins1_immediate_i;
    preg_t ins0_dest_i, ins1_dest_i;
    pack_id_t pack_id_i;
    iq_entry_t p0_data_i, p1_data_i;
    logic p0_vld_i, p0_rs1_vld_i, p0_rs2_vld_i, p0_rs1_rdy_i, p0_rs2_rdy_i;
    logic p1_vld_i, p1_rs1_vld_i, p1_rs2_vld_i, p1_rs1_rdy_i, p1_rs2_rdy_i;
    logic eu2_v_i;
    preg_t eu2_dest_i;
    logic p0_busy_o, p1_busy_o;
    preg_t ex00_rs1_o, ex00_rs2_o, ex10_rs1_o, ex10_rs2_o;
    xlen_t ex00_rs1_data_i, ex00_rs2_data_i, ex10_rs1_data_i, ex10_rs2_data_i;
    xlen_t p0_we_data_o, p1_we_data_o;
    preg_t p0_we_dest_o, p1_we_dest_o;
    logic p0_wen_o, p1_wen_o;
    logic alu0_complete_o, alu1_complete_o;
    rob_id_t alu0_rob_id_o, alu1_rob_id_o;
    logic alu0_reg_ready_o, alu1_reg_ready_o;
    preg_t alu0_reg_dest_o, alu1_reg_dest_o;

    test_row_t rows [NROWS];
    xlen_t rf [64];
    xlen_t gold [64];
    int pend_rob[$];
    int pend_row[$];
    xlen_t pend_val[$];
    preg_t pend_dest[$];
    int err_cnt = 0;
    int test_cnt = 0;
    int fail_cnt = 0;
    int cycle_cnt = 0;
    int seed_val;

    int_cluster dut (.*);

    always #2 cpu_clock_i = ~cpu_clock_i;

    // Register file model, tag 0 always reads as zero
    assign ex00_rs1_data_i = (ex00_rs1_o == '0) ? '0 : rf[ex00_rs1_o];
    assign ex00_rs2_data_i = (ex00_rs2_o == '0) ? '0 : rf[ex00_rs2_o];
    assign ex10_rs1_data_i = (ex10_rs1_o == '0) ? '0 : rf[ex10_rs1_o];
    assign ex10_rs2_data_i = (ex10_rs2_o == '0) ? '0 : rf[ex10_rs2_o];

    always @(posedge cpu_clock_i) begin
        if (p0_wen_o && p0_we_dest_o != '0) rf[p0_we_dest_o] <= p0_we_data_o;
        if (p1_wen_o && p1_we_dest_o != '0) rf[p1_we_dest_o] <= p1_we_data_o;
    end

    always @(posedge cpu_clock_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    function automatic xlen_t alu_model(input alu_op_t op, input xlen_t a, input xlen_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return xlen_t'($signed(a) >>> b[4:0]);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'hx;
        endcase
    endfunction

    // Matches a completion against the outstanding ROB ids
    task automatic handle_completion(input int port, input rob_id_t rob, input logic wen,
                                     input preg_t dest, input xlen_t data,
                                     input logic rdy, input preg_t rdest);
        int idx;
        int e0;
        idx = -1;
        e0 = err_cnt;
        foreach (pend_rob[i]) begin
            if (pend_rob[i] == int'(rob)) idx = i;
        end
        if (idx < 0) begin
            $display("unexpected completion of rob %0d on port %0d at t=%0t", rob, port, $time);
            err_cnt++;
        end else begin
            if (pend_dest[idx] == '0) begin
                check("wen", 0, wen);
                check("reg_ready", 0, rdy);
            end else begin
                check("wen", 1, wen);
                check("we_dest", pend_dest[idx], dest);
                check("we_data", pend_val[idx], data);
                check("reg_ready", 1, rdy);
                check("reg_dest", pend_dest[idx], rdest);
            end
            test_cnt++;
            if (err_cnt != e0) fail_cnt++;
            $display("test %0d rob %0d port %0d: %s", pend_row[idx], rob, port,
                     (err_cnt != e0) ? "FAIL" : "ok");
            pend_rob.delete(idx);
            pend_row.delete(idx);
            pend_val.delete(idx);
            pend_dest.delete(idx);
        end
    endtask

    always @(posedge cpu_clock_i) begin
        if (!rst_i && alu0_complete_o)
            handle_completion(0, alu0_rob_id_o, p0_wen_o, p0_we_dest_o, p0_we_data_o,
                              alu0_reg_ready_o, alu0_reg_dest_o);
        if (!rst_i && alu1_complete_o)
            handle_completion(1, alu1_rob_id_o, p1_wen_o, p1_we_dest_o, p1_we_data_o,
                              alu1_reg_ready_o, alu1_reg_dest_o);
    end

    // Drives one row on an insert port; the caller owns the clock edge
    task automatic drive_row(input int idx, input int port, input logic rs1_rdy);
        test_row_t r;
        xlen_t exp;
        r = rows[idx];
        exp = alu_model(r.op, gold[r.rs1], r.imm ? r.immediate : gold[r.rs2]);
        if (r.dest != '0) gold[r.dest] = exp;
        pend_rob.push_back({r.pack, r.slot});
        pend_row.push_back(idx);
        pend_val.push_back(exp);
        pend_dest.push_back(r.dest);
        pack_id_i <= r.pack;
        // Instruction RAM write port is chosen by the slot within the pack
        if (r.slot == 1'b0) begin
            ins0_op_i <= r.op;
            ins0_imm_i <= r.imm;
            ins0_immediate_i <= r.immediate;
            ins0_dest_i <= r.dest;
            ins0_valid_i <= 1'b1;
        end else begin
            ins1_op_i <= r.op;
            ins1_imm_i <= r.imm;
            ins1_immediate_i <= r.immediate;
            ins1_dest_i <= r.dest;
            ins1_valid_i <= 1'b1;
        end
        if (port == 0) begin
            p0_data_i <= '{rob_id: {r.pack, r.slot}, rs1: r.rs1, rs2: r.rs2};
            p0_vld_i <= 1'b1;
            p0_rs1_vld_i <= 1'b1;
            p0_rs2_vld_i <= !r.imm;
            p0_rs1_rdy_i <= rs1_rdy;
            p0_rs2_rdy_i <= 1'b1;
        end else begin
            p1_data_i <= '{rob_id: {r.pack, r.slot}, rs1: r.rs1, rs2: r.rs2};
            p1_vld_i <= 1'b1;
            p1_rs1_vld_i <= 1'b1;
            p1_rs2_vld_i <= !r.imm;
            p1_rs1_rdy_i <= rs1_rdy;
            p1_rs2_rdy_i <= 1'b1;
        end
    endtask

    task automatic end_insert();
        @(posedge cpu_clock_i);
        ins0_valid_i <= 1'b0;
        ins1_valid_i <= 1'b0;
        p0_vld_i <= 1'b0;
        p1_vld_i <= 1'b0;
    endtask

    task automatic wait_drain();
        while (pend_rob.size() > 0) @(posedge cpu_clock_i);
        repeat (2) @(posedge cpu_clock_i);
    endtask

    // Fills the queue with entries that never wake, then flushes them
    task automatic flush_test();
        int e0;
        e0 = err_cnt;
        for (int k = 0; k < 7; k++) begin
            @(posedge cpu_clock_i);
            pack_id_i <= pack_id_t'(11 + k / 2);
            p0_data_i <= '{rob_id: rob_id_t'(22 + k), rs1: preg_t'(50 + k), rs2: preg_t'(1)};
            p0_vld_i <= 1'b1;
            p0_rs1_vld_i <= 1'b1;
            p0_rs2_vld_i <= 1'b1;
            p0_rs1_rdy_i <= 1'b0;
            p0_rs2_rdy_i <= 1'b1;
            end_insert();
        end
        @(negedge cpu_clock_i);
        check("p0_busy", 1, p0_busy_o);
        check("p1_busy", 1, p1_busy_o);
        @(posedge cpu_clock_i);
        flush_i <= 1'b1;
        @(posedge cpu_clock_i);
        flush_i <= 1'b0;
        @(negedge cpu_clock_i);
        check("p0_busy", 0, p0_busy_o);
        check("p1_busy", 0, p1_busy_o);
        // Wake the flushed tags so that any surviving entry would issue
        for (int k = 0; k < 7; k++) begin
            @(posedge cpu_clock_i);
            eu2_v_i <= 1'b1;
            eu2_dest_i <= preg_t'(50 + k);
        end
        @(posedge cpu_clock_i);
        eu2_v_i <= 1'b0;
        repeat (20) @(posedge cpu_clock_i);
        test_cnt++;
        if (err_cnt != e0) fail_cnt++;
        $display("test flush: %s", (err_cnt != e0) ? "FAIL" : "ok");
    endtask

    initial begin
        int i;
        seed_val = $urandom(32'h3c01);
        rst_i = 1'b1;
        flush_i = 1'b0;
        ins0_op_i = ALU_ADD;
        ins1_op_i = ALU_ADD;
        ins0_imm_i = 1'b0;
        ins1_imm_i = 1'b0;
        ins0_immediate_i = '0;
        ins1_immediate_i = '0;
        ins0_dest_i = '0;
        ins1_dest_i = '0;
        ins0_valid_i = 1'b0;
        ins1_valid_i = 1'b0;
        pack_id_i = '0;
        p0_data_i = '0;
        p1_data_i = '0;
        {p0_vld_i, p0_rs1_vld_i, p0_rs2_vld_i, p0_rs1_rdy_i, p0_rs2_rdy_i} = '0;
        {p1_vld_i, p1_rs1_vld_i, p1_rs2_vld_i, p1_rs1_rdy_i, p1_rs2_rdy_i} = '0;
        eu2_v_i = 1'b0;
        eu2_dest_i = '0;
        rf[0] = '0;
        for (int t = 1; t < 64; t++) rf[t] = $urandom;
        gold = rf;

        // op, imm, immediate, rs1, rs2, dest, pack, slot, mode
        rows[0]  = '{ALU_ADD,  0, 0, 1, 2, 20, 0, 0, M_RDY};
        rows[1]  = '{ALU_SUB,  0, 0, 3, 4, 21, 0, 1, M_RDY};
        rows[2]  = '{ALU_AND,  0, 0, 5, 6, 22, 1, 0, M_RDY};
        rows[3]  = '{ALU_OR,   0, 0, 7, 8, 23, 1, 1, M_RDY};
        rows[4]  = '{ALU_XOR,  0, 0, 9, 10, 24, 2, 0, M_RDY};
        rows[5]  = '{ALU_SLL,  0, 0, 11, 12, 25, 2, 1, M_RDY};
        rows[6]  = '{ALU_SRL,  0, 0, 13, 14, 26, 3, 0, M_RDY};
        rows[7]  = '{ALU_SRA,  0, 0, 15, 16, 27, 3, 1, M_RDY};
        rows[8]  = '{ALU_SLT,  0, 0, 17, 18, 28, 4, 0, M_RDY};
        rows[9]  = '{ALU_SLTU, 0, 0, 19, 1, 29, 4, 1, M_RDY};
        rows[10] = '{ALU_ADD,  1, 32'h0000_0123, 2, 9, 30, 5, 0, M_RDY};
        rows[11] = '{ALU_SRA,  1, 32'd7, 3, 9, 31, 5, 1, M_RDY};
        rows[12] = '{ALU_SLT,  1, 32'hffff_fff0, 4, 9, 32, 6, 0, M_RDY};
        rows[13] = '{ALU_ADD,  0, 0, 5, 6, 0, 6, 1, M_RDY};
        rows[14] = '{ALU_ADD,  0, 0, 40, 7, 33, 7, 0, M_EU2};
        rows[15] = '{ALU_ADD,  0, 0, 20, 1, 34, 7, 1, M_RDY};
        rows[16] = '{ALU_SUB,  0, 0, 34, 2, 35, 8, 0, M_PREV};
        rows[17] = '{ALU_SLL,  1, 32'd3, 35, 9, 36, 8, 1, M_PREV};
        rows[18] = '{ALU_ADD,  0, 0, 1, 3, 37, 9, 0, M_PAIR};
        rows[19] = '{ALU_XOR,  0, 0, 2, 4, 38, 9, 1, M_PAIR};
        rows[20] = '{ALU_SUB,  0, 0, 5, 7, 39, 10, 0, M_PAIR};
        rows[21] = '{ALU_SLTU, 0, 0, 6, 8, 41, 10, 1, M_PAIR};

        repeat (3) @(posedge cpu_clock_i);
        rst_i <= 1'b0;
        @(posedge cpu_clock_i);

        i = 0;
        while (i < NROWS) begin
            @(posedge cpu_clock_i);
            if (rows[i].mode == M_PAIR) begin
                drive_row(i, 0, 1'b1);
                drive_row(i + 1, 1, 1'b1);
                end_insert();
                i = i + 2;
                if (i >= NROWS || rows[i].mode != M_PAIR) wait_drain();
            end else begin
                drive_row(i, 0, rows[i].mode == M_RDY);
                end_insert();
                if (rows[i].mode == M_EU2) begin
                    repeat (6) @(posedge cpu_clock_i);
                    check("pending before wakeup", 1, pend_rob.size());
                    eu2_v_i <= 1'b1;
                    eu2_dest_i <= rows[i].rs1;
                    @(posedge cpu_clock_i);
                    eu2_v_i <= 1'b0;
                end
                i = i + 1;
                if (i >= NROWS || rows[i].mode != M_PREV) wait_drain();
            end
        end

        flush_test();

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && test_cnt == NROWS + 1) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* src/int_cluster.sv */
// Integer execution cluster top

`timescale 1ns/10ps
`include "int_cluster_macros.svh"

module int_cluster import int_cluster_pkg::*; (
    input  wire logic      cpu_clock_i,
    input  wire logic      rst_i,
    input  wire logic      flush_i,

    input  wire alu_op_t   ins0_op_i,
    input  wire logic      ins0_imm_i,
    input  wire xlen_t     ins0_immediate_i,
    input  wire preg_t     ins0_dest_i,
    input  wire logic      ins0_valid_i,
    input  wire alu_op_t   ins1_op_i,
    input  wire logic      ins1_imm_i,
    input  wire xlen_t     ins1_immediate_i,
    input  wire preg_t     ins1_dest_i,
    input  wire logic      ins1_valid_i,
    input  wire pack_id_t  pack_id_i,

    input  wire iq_entry_t p0_data_i,
    input  wire logic      p0_vld_i,
    input  wire logic      p0_rs1_vld_i,
    input  wire logic      p0_rs2_vld_i,
    input  wire logic      p0_rs1_rdy_i,
    input  wire logic      p0_rs2_rdy_i,
    input  wire iq_entry_t p1_data_i,
    input  wire logic      p1_vld_i,
    input  wire logic      p1_rs1_vld_i,
    input  wire logic      p1_rs2_vld_i,
    input  wire logic      p1_rs1_rdy_i,
    input  wire logic      p1_rs2_rdy_i,
    output logic           p0_busy_o,
    output logic           p1_busy_o,

    // Memory pipeline wakeup
    input  wire logic      eu2_v_i,
    input  wire preg_t     eu2_dest_i,

    // Register file
    output preg_t          ex00_rs1_o,
    output preg_t          ex00_rs2_o,
    input  wire xlen_t     ex00_rs1_data_i,
    input  wire xlen_t     ex00_rs2_data_i,
    output preg_t          ex10_rs1_o,
    output preg_t          ex10_rs2_o,
    input  wire xlen_t     ex10_rs1_data_i,
    input  wire xlen_t     ex10_rs2_data_i,
    output xlen_t          p0_we_data_o,
    output preg_t          p0_we_dest_o,
    output logic           p0_wen_o,
    output xlen_t          p1_we_data_o,
    output preg_t          p1_we_dest_o,
    output logic           p1_wen_o,

    // ROB completion and register ready
    output logic           alu0_complete_o,
    output rob_id_t        alu0_rob_id_o,
    output logic           alu1_complete_o,
    output rob_id_t        alu1_rob_id_o,
    output logic           alu0_reg_ready_o,
    output preg_t          alu0_reg_dest_o,
    output logic           alu1_reg_ready_o,
    output preg_t          alu1_reg_dest_o
);
    logic      iss0_vld;
    logic      iss1_vld;
    iq_entry_t iss0_entry;
    iq_entry_t iss1_entry;

    rob_id_t   rd0_rob;
    rob_id_t   rd1_rob;
    alu_op_t   rd0_op;
    alu_op_t   rd1_op;
    logic      rd0_imm;
    logic      rd1_imm;
    xlen_t     rd0_immediate;
    xlen_t     rd1_immediate;
    preg_t     rd0_dest;
    preg_t     rd1_dest;

    xlen_t     alu0_a;
    xlen_t     alu0_b;
    alu_op_t   alu0_op;
    rob_id_t   alu0_rob;
    preg_t     alu0_dest;
    logic      alu0_valid;
    xlen_t     alu1_a;
    xlen_t     alu1_b;
    alu_op_t   alu1_op;
    rob_id_t   alu1_rob;
    preg_t     alu1_dest;
    logic      alu1_valid;

    instr_ram u_instr_ram (
        .cpu_clock_i      (cpu_clock_i),
        .ins0_op_i        (ins0_op_i),
        .ins0_imm_i       (ins0_imm_i),
        .ins0_immediate_i (ins0_immediate_i),
        .ins0_dest_i      (ins0_dest_i),
        .ins0_valid_i     (ins0_valid_i),
        .ins1_op_i        (ins1_op_i),
        .ins1_imm_i       (ins1_imm_i),
        .ins1_immediate_i (ins1_immediate_i),
        .ins1_dest_i      (ins1_dest_i),
        .ins1_valid_i     (ins1_valid_i),
        .pack_id_i        (pack_id_i),
        .rd0_rob_i        (rd0_rob),
        .rd0_op_o         (rd0_op),
        .rd0_imm_o        (rd0_imm),
        .rd0_immediate_o  (rd0_immediate),
        .rd0_dest_o       (rd0_dest),
        .rd1_rob_i        (rd1_rob),
        .rd1_op_o         (rd1_op),
        .rd1_imm_o        (rd1_imm),
        .rd1_immediate_o  (rd1_immediate),
        .rd1_dest_o       (rd1_dest)
    );

    // ALU write-back wakes the queue alongside the memory pipeline
    issue_queue u_issue_queue (
        .cpu_clock_i  (cpu_clock_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .p0_data_i    (p0_data_i),
        .p0_vld_i     (p0_vld_i),
        .p0_rs1_vld_i (p0_rs1_vld_i),
        .p0_rs2_vld_i (p0_rs2_vld_i),
        .p0_rs1_rdy_i (p0_rs1_rdy_i),
        .p0_rs2_rdy_i (p0_rs2_rdy_i),
        .p1_data_i    (p1_data_i),
        .p1_vld_i     (p1_vld_i),
        .p1_rs1_vld_i (p1_rs1_vld_i),
        .p1_rs2_vld_i (p1_rs2_vld_i),
        .p1_rs1_rdy_i (p1_rs1_rdy_i),
        .p1_rs2_rdy_i (p1_rs2_rdy_i),
        .wk0_v_i      (alu0_reg_ready_o),
        .wk0_dest_i   (alu0_reg_dest_o),
        .wk1_v_i      (alu1_reg_ready_o),
        .wk1_dest_i   (alu1_reg_dest_o),
        .wk2_v_i      (eu2_v_i),
        .wk2_dest_i   (eu2_dest_i),
        .p0_busy_o    (p0_busy_o),
        .p1_busy_o    (p1_busy_o),
        .iss0_vld_o   (iss0_vld),
        .iss0_entry_o (iss0_entry),
        .iss1_vld_o   (iss1_vld),
        .iss1_entry_o (iss1_entry)
    );

    operand_stage u_opnd0 (
        .iss_vld_i   (iss0_vld),
        .iss_entry_i (iss0_entry),
        .rs1_o       (ex00_rs1_o),
        .rs2_o       (ex00_rs2_o),
        .rs1_data_i  (ex00_rs1_data_i),
        .rs2_data_i  (ex00_rs2_data_i),
        .rob_rd_o    (rd0_rob),
        .op_i        (rd0_op),
        .imm_i       (rd0_imm),
        .immediate_i (rd0_immediate),
        .dest_i      (rd0_dest),
        .a_o         (alu0_a),
        .b_o         (alu0_b),
        .op_o        (alu0_op),
        .rob_id_o    (alu0_rob),
        .dest_o      (alu0_dest),
        .valid_o     (alu0_valid)
    );

    operand_stage u_opnd1 (
        .iss_vld_i   (iss1_vld),
        .iss_entry_i (iss1_entry),
        .rs1_o       (ex10_rs1_o),
        .rs2_o       (ex10_rs2_o),
        .rs1_data_i  (ex10_rs1_data_i),
        .rs2_data_i  (ex10_rs2_data_i),
        .rob_rd_o    (rd1_rob),
        .op_i        (rd1_op),
        .imm_i       (rd1_imm),
        .immediate_i (rd1_immediate),
        .dest_i      (rd1_dest),
        .a_o         (alu1_a),
        .b_o         (alu1_b),
        .op_o        (alu1_op),
        .rob_id_o    (alu1_rob),
        .dest_o      (alu1_dest),
        .valid_o     (alu1_valid)
    );

    int_alu u_alu0 (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .a_i         (alu0_a),
        .b_i         (alu0_b),
        .op_i        (alu0_op),
        .rob_id_i    (alu0_rob),
        .dest_i      (alu0_dest),
        .valid_i     (alu0_valid),
        .we_data_o   (p0_we_data_o),
        .we_dest_o   (p0_we_dest_o),
        .wen_o       (p0_wen_o),
        .complete_o  (alu0_complete_o),
        .rob_id_o    (alu0_rob_id_o),
        .reg_ready_o (alu0_reg_ready_o),
        .reg_dest_o  (alu0_reg_dest_o)
    );

    int_alu u_alu1 (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .a_i         (alu1_a),
        .b_i         (alu1_b),
        .op_i        (alu1_op),
        .rob_id_i    (alu1_rob),
        .dest_i      (alu1_dest),
        .valid_i     (alu1_valid),
        .we_data_o   (p1_we_data_o),
        .we_dest_o   (p1_we_dest_o),
        .wen_o       (p1_wen_o),
        .complete_o  (alu1_complete_o),
        .rob_id_o    (alu1_rob_id_o),
        .reg_ready_o (alu1_reg_ready_o),
        .reg_dest_o  (alu1_reg_dest_o)
    );

endmodule

/* src/int_alu.sv */
// Integer ALU with write-back register

`timescale 1ns/10ps
`include "int_cluster_macros.svh"

module int_alu import int_cluster_pkg::*; (
    input  wire logic    cpu_clock_i,
    input  wire logic    rst_i,
    input  wire logic    flush_i,

    input  wire xlen_t   a_i,
    input  wire xlen_t   b_i,
    input  wire alu_op_t op_i,
    input  wire rob_id_t rob_id_i,
    input  wire preg_t   dest_i,
    input  wire logic    valid_i,

    output xlen_t        we_data_o,
    output preg_t        we_dest_o,
    output logic         wen_o,
    output logic         complete_o,
    output rob_id_t      rob_id_o,
    output logic         reg_ready_o,
    output preg_t        reg_dest_o
);
    xlen_t      result;
    logic [4:0] shamt;
    logic       vld_q;
    logic       wen_q;
    xlen_t      result_q;
    preg_t      dest_q;
    rob_id_t    rob_q;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result = a_i + b_i;
            ALU_SUB:  result = a_i - b_i;
            ALU_AND:  result = a_i & b_i;
            ALU_OR:   result = a_i | b_i;
            ALU_XOR:  result = a_i ^ b_i;
            ALU_SLL:  result = a_i << shamt;
            ALU_SRL:  result = a_i >> shamt;
            ALU_SRA:  result = xlen_t'($signed(a_i) >>> shamt);
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, a_i < b_i};
            default:  result = a_i + b_i;
        endcase
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i || flush_i) begin
            vld_q <= 1'b0;
            wen_q <= 1'b0;
        end else begin
            vld_q <= valid_i;
            // Writes to the zero register are dropped
            wen_q <= valid_i && (dest_i != '0);
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        result_q <= result;
        dest_q   <= dest_i;
        rob_q    <= rob_id_i;
    end

    assign we_data_o   = result_q;
    assign we_dest_o   = dest_q;
    assign wen_o       = wen_q;
    assign complete_o  = vld_q;
    assign rob_id_o    = rob_q;
    // Dependents wake once the value is in the register file
    assign reg_ready_o = wen_q;
    assign reg_dest_o  = dest_q;

    a_wen_completes: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        wen_o |-> complete_o && we_dest_o != '0);

endmodule

/* src/operand_stage.sv */
// Register read and operand select

`timescale 1ns/10ps
`include "int_cluster_macros.svh"

module operand_stage import int_cluster_pkg::*; (
    input  wire logic      iss_vld_i,
    input  wire iq_entry_t iss_entry_i,

    // Register file read, data returns in the same cycle
    output preg_t          rs1_o,
    output preg_t          rs2_o,
    input  wire xlen_t     rs1_data_i,
    input  wire xlen_t     rs2_data_i,

    // Instruction RAM lookup
    output rob_id_t        rob_rd_o,
    input  wire alu_op_t   op_i,
    input  wire logic      imm_i,
    input  wire xlen_t     immediate_i,
    input  wire preg_t     dest_i,

    output xlen_t          a_o,
    output xlen_t          b_o,
    output alu_op_t        op_o,
    output rob_id_t        rob_id_o,
    output preg_t          dest_o,
    output logic           valid_o
);
    assign rs1_o    = iss_entry_i.rs1;
    assign rs2_o    = iss_entry_i.rs2;
    assign rob_rd_o = iss_entry_i.rob_id;

    assign a_o = rs1_data_i;
    // Immediate forms take B from the stored immediate
    assign b_o = imm_i ? immediate_i : rs2_data_i;

    assign op_o     = op_i;
    assign rob_id_o = iss_entry_i.rob_id;
    assign dest_o   = dest_i;
    assign valid_o  = iss_vld_i;

endmodule

/* src/instr_ram.sv */
// Per-ROB-entry instruction store

`timescale 1ns/10ps
`include "int_cluster_macros.svh"

module instr_ram import int_cluster_pkg::*; (
    input  wire logic     cpu_clock_i,

    input  wire alu_op_t  ins0_op_i,
    input  wire logic     ins0_imm_i,
    input  wire xlen_t    ins0_immediate_i,
    input  wire preg_t    ins0_dest_i,
    input  wire logic     ins0_valid_i,
    input  wire alu_op_t  ins1_op_i,
    input  wire logic     ins1_imm_i,
    input  wire xlen_t    ins1_immediate_i,
    input  wire preg_t    ins1_dest_i,
    input  wire logic     ins1_valid_i,
    input  wire pack_id_t pack_id_i,

    input  wire rob_id_t  rd0_rob_i,
    output alu_op_t       rd0_op_o,
    output logic          rd0_imm_o,
    output xlen_t         rd0_immediate_o,
    output preg_t         rd0_dest_o,
    input  wire rob_id_t  rd1_rob_i,
    output alu_op_t       rd1_op_o,
    output logic          rd1_imm_o,
    output xlen_t         rd1_immediate_o,
    output preg_t         rd1_dest_o
);
    localparam int DEPTH = 1 << `ROB_W;

    alu_op_t op_mem [DEPTH];
    logic    imm_mem [DEPTH];
    xlen_t   immediate_mem [DEPTH];
    preg_t   dest_mem [DEPTH];

    // Slot 0 lands on the even ROB id of the pack, slot 1 on the odd one
    always_ff @(posedge cpu_clock_i) begin
        if (ins0_valid_i) begin
            op_mem[{pack_id_i, 1'b0}]        <= ins0_op_i;
            imm_mem[{pack_id_i, 1'b0}]       <= ins0_imm_i;
            immediate_mem[{pack_id_i, 1'b0}] <= ins0_immediate_i;
            dest_mem[{pack_id_i, 1'b0}]      <= ins0_dest_i;
        end
        if (ins1_valid_i) begin
            op_mem[{pack_id_i, 1'b1}]        <= ins1_op_i;
            imm_mem[{pack_id_i, 1'b1}]       <= ins1_imm_i;
            immediate_mem[{pack_id_i, 1'b1}] <= ins1_immediate_i;
            dest_mem[{pack_id_i, 1'b1}]      <= ins1_dest_i;
        end
    end

    // One asynchronous read port per issue port
    assign rd0_op_o        = op_mem[rd0_rob_i];
    assign rd0_imm_o       = imm_mem[rd0_rob_i];
    assign rd0_immediate_o = immediate_mem[rd0_rob_i];
    assign rd0_dest_o      = dest_mem[rd0_rob_i];
    assign rd1_op_o        = op_mem[rd1_rob_i];
    assign rd1_imm_o       = imm_mem[rd1_rob_i];
    assign rd1_immediate_o = immediate_mem[rd1_rob_i];
    assign rd1_dest_o      = dest_mem[rd1_rob_i];

endmodule

/* issue/issue_queue.sv */
// Unified integer issue queue

`timescale 1ns/10ps
`include "int_cluster_macros.svh"

module issue_queue import int_cluster_pkg::*; (
    input  wire logic      cpu_clock_i,
    input  wire logic      rst_i,
    input  wire logic      flush_i,

    input  wire iq_entry_t p0_data_i,
    input  wire logic      p0_vld_i,
    input  wire logic      p0_rs1_vld_i,
    input  wire logic      p0_rs2_vld_i,
    input  wire logic      p0_rs1_rdy_i,
    input  wire logic      p0_rs2_rdy_i,
    input  wire iq_entry_t p1_data_i,
    input  wire logic      p1_vld_i,
    input  wire logic      p1_rs1_vld_i,
    input  wire logic      p1_rs2_vld_i,
    input  wire logic      p1_rs1_rdy_i,
    input  wire logic      p1_rs2_rdy_i,

    // Wakeup broadcasts from ALU0, ALU1 and the memory pipeline
    input  wire logic      wk0_v_i,
    input  wire preg_t     wk0_dest_i,
    input  wire logic      wk1_v_i,
    input  wire preg_t     wk1_dest_i,
    input  wire logic      wk2_v_i,
    input  wire preg_t     wk2_dest_i,

    output logic           p0_busy_o,
    output logic           p1_busy_o,

    output logic           iss0_vld_o,
    output iq_entry_t      iss0_entry_o,
    output logic           iss1_vld_o,
    output iq_entry_t      iss1_entry_o
);
    localparam int IDX_W = $clog2(`IQ_DEPTH);

    iq_entry_t            entry_q [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] vld_q;
    logic [`IQ_DEPTH-1:0] rs1_rdy_q;
    logic [`IQ_DEPTH-1:0] rs2_rdy_q;
    logic [`IQ_DEPTH-1:0] rdy_vec;

    logic [IDX_W:0]       free_cnt;
    logic [IDX_W-1:0]     free0_idx;
    logic [IDX_W-1:0]     free1_idx;
    logic [IDX_W-1:0]     p1_slot;
    logic [1:0]           ins_cnt;

    logic                 sel0_v;
    logic                 sel1_v;
    logic [IDX_W-1:0]     sel0_idx;
    logic [IDX_W-1:0]     sel1_idx;

    function automatic logic wake_hit(input preg_t tag);
        return (wk0_v_i && wk0_dest_i == tag) ||
               (wk1_v_i && wk1_dest_i == tag) ||
               (wk2_v_i && wk2_dest_i == tag);
    endfunction

    assign rdy_vec = vld_q & rs1_rdy_q & rs2_rdy_q;

    // Two lowest free slots and two lowest ready entries
    always_comb begin
        free_cnt  = '0;
        free0_idx = '0;
        free1_idx = '0;
        sel0_v    = 1'b0;
        sel1_v    = 1'b0;
        sel0_idx  = '0;
        sel1_idx  = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (!vld_q[i]) begin
                if (free_cnt == 0) begin
                    free0_idx = IDX_W'(i);
                end else if (free_cnt == 1) begin
                    free1_idx = IDX_W'(i);
                end
                free_cnt = free_cnt + 1'b1;
            end
            if (rdy_vec[i]) begin
                if (!sel0_v) begin
                    sel0_v   = 1'b1;
                    sel0_idx = IDX_W'(i);
                end else if (!sel1_v) begin
                    sel1_v   = 1'b1;
                    sel1_idx = IDX_W'(i);
                end
            end
        end
    end

    // A lone port 1 insert takes the lowest free slot
    assign p1_slot   = p0_vld_i ? free1_idx : free0_idx;
    assign ins_cnt   = {1'b0, p0_vld_i} + {1'b0, p1_vld_i};
    assign p0_busy_o = free_cnt < 2;
    assign p1_busy_o = free_cnt < 2;

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i || flush_i) begin
            vld_q      <= '0;
            iss0_vld_o <= 1'b0;
            iss1_vld_o <= 1'b0;
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (vld_q[i] && wake_hit(entry_q[i].rs1)) begin
                    rs1_rdy_q[i] <= 1'b1;
                end
                if (vld_q[i] && wake_hit(entry_q[i].rs2)) begin
                    rs2_rdy_q[i] <= 1'b1;
                end
            end
            if (sel0_v) begin
                vld_q[sel0_idx] <= 1'b0;
            end
            if (sel1_v) begin
                vld_q[sel1_idx] <= 1'b0;
            end
            // Unused sources count as ready
            if (p0_vld_i) begin
                vld_q[free0_idx]     <= 1'b1;
                rs1_rdy_q[free0_idx] <= !p0_rs1_vld_i || p0_rs1_rdy_i;
                rs2_rdy_q[free0_idx] <= !p0_rs2_vld_i || p0_rs2_rdy_i;
            end
            if (p1_vld_i) begin
                vld_q[p1_slot]     <= 1'b1;
                rs1_rdy_q[p1_slot] <= !p1_rs1_vld_i || p1_rs1_rdy_i;
                rs2_rdy_q[p1_slot] <= !p1_rs2_vld_i || p1_rs2_rdy_i;
            end
            iss0_vld_o <= sel0_v;
            iss1_vld_o <= sel1_v;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (p0_vld_i) begin
            entry_q[free0_idx] <= p0_data_i;
        end
        if (p1_vld_i) begin
            entry_q[p1_slot] <= p1_data_i;
        end
        if (sel0_v) begin
            iss0_entry_o <= entry_q[sel0_idx];
        end
        if (sel1_v) begin
            iss1_entry_o <= entry_q[sel1_idx];
        end
    end

    a_iss1_needs_iss0: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        iss1_vld_o |-> iss0_vld_o);

    a_iss_distinct: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        iss1_vld_o |-> iss0_entry_o.rob_id != iss1_entry_o.rob_id);

    a_no_insert_when_full: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        (p0_vld_i || p1_vld_i) |-> free_cnt >= ins_cnt);

endmodule

/* common/int_cluster_pkg.sv */
// Integer cluster shared types

`include "int_cluster_macros.svh"

package int_cluster_pkg;

    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`ROB_W-1:0] rob_id_t;
    typedef logic [`PACK_W-1:0] pack_id_t;
    typedef logic [`XLEN-1:0] xlen_t;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // Issue payload, the ROB id doubles as the instruction RAM address
    typedef struct packed {
        rob_id_t rob_id;
        preg_t   rs1;
        preg_t   rs2;
    } iq_entry_t;

endpackage

/* common/int_cluster_macros.svh */
// Integer cluster widths and depths

`ifndef INT_CLUSTER_MACROS_SVH
`define INT_CLUSTER_MACROS_SVH

// Physical register tag width, tag 0 is the zero register
`define PREG_W 6

// ROB id is the pack id with the slot bit appended
`define ROB_W 5
`define PACK_W 4

`define XLEN 32

// Unified issue queue entries
`define IQ_DEPTH 8

`define ALU_OP_W 4

`endif
